/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [31:0] pc_t;

    // all-zero value is add, so a cleared control word is harmless
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_t;

    // rv32i major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 values
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;

    // funct7 values
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // forwarding mux selections
    localparam logic [1:0] fwd_reg = 2'b00;
    localparam logic [1:0] fwd_mem = 2'b01;
    localparam logic [1:0] fwd_wb  = 2'b10;

endpackage

`default_nettype wire

/* verilog/program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module program_memory #(
    parameter int imem_words = 256
) (
    input  logic                          clk,
    input  logic                          write_en,
    input  logic [$clog2(imem_words)-1:0] write_addr,
    input  cpu_pkg::word_t                write_data,
    input  cpu_pkg::pc_t                  read_addr,
    output cpu_pkg::word_t                read_data
);
    import cpu_pkg::*;

    localparam int addr_w = $clog2(imem_words);

    word_t mem [imem_words];
    logic  in_range;

    // loader writes whole words while the core is halted
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // byte address to word index, past the end reads as a no-op
    assign in_range  = read_addr[31:2] < 30'(imem_words);
    assign read_data = in_range ? mem[read_addr[addr_w+1:2]] : '0;

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         run,
    input  logic         stall,
    input  logic         branch_taken,
    input  cpu_pkg::pc_t branch_target,
    output cpu_pkg::pc_t fetch_addr,
    output logic         fetch_valid
);
    import cpu_pkg::*;

    pc_t pc;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
        end else if (!run) begin
            // halted, so the first fetch after run is address 0
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign fetch_addr  = pc;
    // bubbles only while halted
    assign fetch_valid = run;

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic             clk,
    input  logic             reset_n,
    input  cpu_pkg::word_t   instruction,
    input  logic             valid,
    input  logic             write_en,
    input  cpu_pkg::reg_id_t write_id,
    input  cpu_pkg::word_t   write_data,
    output cpu_pkg::reg_id_t rs1_id,
    output cpu_pkg::reg_id_t rs2_id,
    output cpu_pkg::reg_id_t rd_id,
    output cpu_pkg::word_t   read_data1,
    output cpu_pkg::word_t   read_data2,
    output cpu_pkg::word_t   immediate,
    output logic             reg_write,
    output logic             mem_read,
    output logic             mem_write,
    output logic             alu_src,
    output logic             branch,
    output cpu_pkg::alu_op_t alu_op
);
    import cpu_pkg::*;

    word_t      regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign rs1_id = instruction[19:15];
    assign rs2_id = instruction[24:20];
    assign rd_id  = instruction[11:7];

    // register file, x0 never written
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_id != '0) begin
            regs[write_id] <= write_data;
        end
    end

    // same-cycle write is visible to the read
    assign read_data1 = (rs1_id == '0) ? '0 :
                        (write_en && write_id == rs1_id) ? write_data : regs[rs1_id];
    assign read_data2 = (rs2_id == '0) ? '0 :
                        (write_en && write_id == rs2_id) ? write_data : regs[rs2_id];

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        alu_src   = 1'b0;
        branch    = 1'b0;
        alu_op    = alu_add;
        if (valid) begin
            case (opcode)
                op_reg: begin
                    reg_write = 1'b1;
                    case (funct3)
                        f3_add_sub: alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
                        f3_slt:     alu_op = alu_slt;
                        f3_xor:     alu_op = alu_xor;
                        f3_or:      alu_op = alu_or;
                        f3_and:     alu_op = alu_and;
                        default:    reg_write = 1'b0;
                    endcase
                    // only base or sub encodings are known
                    if (funct7 != f7_base && funct7 != f7_sub) begin
                        reg_write = 1'b0;
                    end
                end
                op_imm: begin
                    // addi only
                    reg_write = (funct3 == f3_add_sub);
                    alu_src   = (funct3 == f3_add_sub);
                end
                op_load: begin
                    reg_write = (funct3 == f3_word);
                    mem_read  = (funct3 == f3_word);
                    alu_src   = (funct3 == f3_word);
                end
                op_store: begin
                    mem_write = (funct3 == f3_word);
                    alu_src   = (funct3 == f3_word);
                end
                op_branch: begin
                    branch = (funct3 == f3_beq);
                end
                default: ;
            endcase
        end
    end

    // I, S and B immediates
    always_comb begin
        case (opcode)
            op_store:  immediate = {{20{instruction[31]}}, instruction[31:25],
                                    instruction[11:7]};
            op_branch: immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                                    instruction[30:25], instruction[11:8], 1'b0};
            default:   immediate = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  cpu_pkg::word_t   data1,
    input  cpu_pkg::word_t   data2,
    input  cpu_pkg::word_t   immediate,
    input  cpu_pkg::pc_t     pc,
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             alu_src,
    input  logic             branch,
    input  cpu_pkg::word_t   mem_fwd_data,
    input  cpu_pkg::word_t   wb_fwd_data,
    input  logic [1:0]       forward_a,
    input  logic [1:0]       forward_b,
    output cpu_pkg::word_t   alu_result,
    output cpu_pkg::word_t   store_data,
    output logic             branch_taken,
    output cpu_pkg::pc_t     branch_target
);
    import cpu_pkg::*;

    word_t operand_a;
    word_t operand_b;
    word_t alu_b;

    // forwarded register operands
    always_comb begin
        case (forward_a)
            fwd_mem: operand_a = mem_fwd_data;
            fwd_wb:  operand_a = wb_fwd_data;
            default: operand_a = data1;
        endcase
        case (forward_b)
            fwd_mem: operand_b = mem_fwd_data;
            fwd_wb:  operand_b = wb_fwd_data;
            default: operand_b = data2;
        endcase
    end

    assign alu_b      = alu_src ? immediate : operand_b;
    assign store_data = operand_b;

    always_comb begin
        case (alu_op)
            alu_sub: alu_result = operand_a - alu_b;
            alu_and: alu_result = operand_a & alu_b;
            alu_or:  alu_result = operand_a | alu_b;
            alu_xor: alu_result = operand_a ^ alu_b;
            alu_slt: alu_result = {31'd0, $signed(operand_a) < $signed(alu_b)};
            default: alu_result = operand_a + alu_b;
        endcase
    end

    // beq compares the register operands, never the immediate
    assign branch_taken  = branch && (operand_a == operand_b);
    assign branch_target = pc + immediate;

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int dmem_words = 256
) (
    input  logic           clk,
    input  cpu_pkg::word_t address,
    input  cpu_pkg::word_t store_data,
    input  logic           mem_write,
    input  logic           mem_read,
    output cpu_pkg::word_t load_data
);
    import cpu_pkg::*;

    localparam int addr_w = $clog2(dmem_words);

    word_t            mem [dmem_words];
    logic [addr_w-1:0] index;
    logic             in_range;

    // word aligned only, low two bits ignored
    assign index    = address[addr_w+1:2];
    assign in_range = address[31:2] < 30'(dmem_words);

    always_ff @(posedge clk) begin
        if (mem_write && in_range) begin
            mem[index] <= store_data;
        end
    end

    assign load_data = (mem_read && in_range) ? mem[index] : '0;

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_id_t id_rs1,
    input  cpu_pkg::reg_id_t id_rs2,
    input  cpu_pkg::reg_id_t ex_rs1,
    input  cpu_pkg::reg_id_t ex_rs2,
    input  cpu_pkg::reg_id_t ex_rd,
    input  logic             ex_mem_read,
    input  cpu_pkg::reg_id_t mem_rd,
    input  logic             mem_reg_write,
    input  cpu_pkg::reg_id_t wb_rd,
    input  logic             wb_reg_write,
    output logic [1:0]       forward_a,
    output logic [1:0]       forward_b,
    output logic             load_stall
);
    import cpu_pkg::*;

    logic mem_live;
    logic wb_live;

    // x0 results are never forwarded
    assign mem_live = mem_reg_write && mem_rd != '0;
    assign wb_live  = wb_reg_write && wb_rd != '0;

    // younger result in memory stage wins
    assign forward_a = (mem_live && mem_rd == ex_rs1) ? fwd_mem :
                       (wb_live && wb_rd == ex_rs1)   ? fwd_wb  : fwd_reg;
    assign forward_b = (mem_live && mem_rd == ex_rs2) ? fwd_mem :
                       (wb_live && wb_rd == ex_rs2)   ? fwd_wb  : fwd_reg;

    // load data is only ready after the memory stage
    assign load_stall = ex_mem_read && ex_rd != '0 &&
                        (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          run,
    input  logic                          prog_valid,
    input  logic [$clog2(imem_words)-1:0] prog_addr,
    input  cpu_pkg::word_t                prog_data,
    output logic                          prog_ready,
    output logic                          retire_valid,
    output cpu_pkg::reg_id_t              retire_rd,
    output cpu_pkg::word_t                retire_data
);
    import cpu_pkg::*;

    // fetch
    pc_t     fetch_addr;
    logic    fetch_valid;
    word_t   imem_data;

    // decode outputs
    reg_id_t dec_rs1, dec_rs2, dec_rd;
    word_t   dec_data1, dec_data2, dec_imm;
    logic    dec_reg_write, dec_mem_read, dec_mem_write, dec_alu_src, dec_branch;
    alu_op_t dec_alu_op;

    // execute, memory and hazard outputs
    word_t   ex_alu_result, ex_store_data, mem_load_data, wb_result;
    logic    branch_taken, load_stall;
    pc_t     branch_target;
    logic [1:0] forward_a, forward_b;

    // IF/ID
    logic    ifid_valid;
    word_t   ifid_instr;
    pc_t     ifid_pc;

    // ID/EX
    logic    idex_reg_write, idex_mem_read, idex_mem_write, idex_alu_src, idex_branch;
    alu_op_t idex_alu_op;
    reg_id_t idex_rs1, idex_rs2, idex_rd;
    word_t   idex_data1, idex_data2, idex_imm;
    pc_t     idex_pc;

    // EX/MEM
    logic    exmem_reg_write, exmem_mem_read, exmem_mem_write;
    reg_id_t exmem_rd;
    word_t   exmem_alu_result, exmem_store_data;

    // MEM/WB
    logic    memwb_reg_write, memwb_mem_read;
    reg_id_t memwb_rd;
    word_t   memwb_alu_result, memwb_load_data;

    assign prog_ready = ~run;

    program_memory #(.imem_words(imem_words)) imem_inst (
        .clk(clk),
        .write_en(prog_valid && prog_ready),
        .write_addr(prog_addr),
        .write_data(prog_data),
        .read_addr(fetch_addr),
        .read_data(imem_data)
    );

    fetch_stage fetch_inst (
        .clk(clk),
        .reset_n(reset_n),
        .run(run),
        .stall(load_stall),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .fetch_addr(fetch_addr),
        .fetch_valid(fetch_valid)
    );

    // IF/ID, flushed by a taken beq, held on a load-use stall
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ifid_valid <= 1'b0;
        end else if (branch_taken) begin
            ifid_valid <= 1'b0;
        end else if (!load_stall) begin
            ifid_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!load_stall) begin
            ifid_instr <= imem_data;
            ifid_pc    <= fetch_addr;
        end
    end

    decode_stage decode_inst (
        .clk(clk),
        .reset_n(reset_n),
        .instruction(ifid_instr),
        .valid(ifid_valid),
        .write_en(memwb_reg_write),
        .write_id(memwb_rd),
        .write_data(wb_result),
        .rs1_id(dec_rs1),
        .rs2_id(dec_rs2),
        .rd_id(dec_rd),
        .read_data1(dec_data1),
        .read_data2(dec_data2),
        .immediate(dec_imm),
        .reg_write(dec_reg_write),
        .mem_read(dec_mem_read),
        .mem_write(dec_mem_write),
        .alu_src(dec_alu_src),
        .branch(dec_branch),
        .alu_op(dec_alu_op)
    );

    // ID/EX control, bubble on flush or stall
    always_ff @(posedge clk) begin
        if (!reset_n || branch_taken || load_stall) begin
            idex_reg_write <= 1'b0;
            idex_mem_read  <= 1'b0;
            idex_mem_write <= 1'b0;
            idex_alu_src   <= 1'b0;
            idex_branch    <= 1'b0;
            idex_alu_op    <= alu_add;
        end else begin
            idex_reg_write <= dec_reg_write;
            idex_mem_read  <= dec_mem_read;
            idex_mem_write <= dec_mem_write;
            idex_alu_src   <= dec_alu_src;
            idex_branch    <= dec_branch;
            idex_alu_op    <= dec_alu_op;
        end
    end

    always_ff @(posedge clk) begin
        idex_rs1   <= dec_rs1;
        idex_rs2   <= dec_rs2;
        idex_rd    <= dec_rd;
        idex_data1 <= dec_data1;
        idex_data2 <= dec_data2;
        idex_imm   <= dec_imm;
        idex_pc    <= ifid_pc;
    end

    hazard_unit hazard_inst (
        .id_rs1(dec_rs1),
        .id_rs2(dec_rs2),
        .ex_rs1(idex_rs1),
        .ex_rs2(idex_rs2),
        .ex_rd(idex_rd),
        .ex_mem_read(idex_mem_read),
        .mem_rd(exmem_rd),
        .mem_reg_write(exmem_reg_write),
        .wb_rd(memwb_rd),
        .wb_reg_write(memwb_reg_write),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .load_stall(load_stall)
    );

    execute_stage execute_inst (
        .data1(idex_data1),
        .data2(idex_data2),
        .immediate(idex_imm),
        .pc(idex_pc),
        .alu_op(idex_alu_op),
        .alu_src(idex_alu_src),
        .branch(idex_branch),
        .mem_fwd_data(exmem_alu_result),
        .wb_fwd_data(wb_result),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .alu_result(ex_alu_result),
        .store_data(ex_store_data),
        .branch_taken(branch_taken),
        .branch_target(branch_target)
    );

    // EX/MEM and MEM/WB
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            exmem_reg_write <= 1'b0;
            exmem_mem_read  <= 1'b0;
            exmem_mem_write <= 1'b0;
            memwb_reg_write <= 1'b0;
            memwb_mem_read  <= 1'b0;
        end else begin
            exmem_reg_write <= idex_reg_write;
            exmem_mem_read  <= idex_mem_read;
            exmem_mem_write <= idex_mem_write;
            memwb_reg_write <= exmem_reg_write;
            memwb_mem_read  <= exmem_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        exmem_rd         <= idex_rd;
        exmem_alu_result <= ex_alu_result;
        exmem_store_data <= ex_store_data;
        memwb_rd         <= exmem_rd;
        memwb_alu_result <= exmem_alu_result;
        memwb_load_data  <= mem_load_data;
    end

    mem_stage #(.dmem_words(dmem_words)) mem_inst (
        .clk(clk),
        .address(exmem_alu_result),
        .store_data(exmem_store_data),
        .mem_write(exmem_mem_write),
        .mem_read(exmem_mem_read),
        .load_data(mem_load_data)
    );

    // write-back value, also the retire payload
    assign wb_result    = memwb_mem_read ? memwb_load_data : memwb_alu_result;
    assign retire_valid = memwb_reg_write && memwb_rd != '0;
    assign retire_rd    = memwb_rd;
    assign retire_data  = wb_result;

endmodule

`default_nettype wire

/* test/cpu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
    input logic             clk,
    input logic             reset_n,
    input logic             run,
    input logic             prog_ready,
    input logic             retire_valid,
    input cpu_pkg::reg_id_t retire_rd
);

    // load port is closed while the core runs
    ready_closed: assert property (@(posedge clk) !(run && prog_ready))
        else $error("prog_ready high while run is high");

    // x0 writes never retire
    no_x0_retire: assert property (@(posedge clk) disable iff (!reset_n)
        retire_valid |-> retire_rd != '0)
        else $error("retire of register x0");

    reset_quiet: assert property (@(posedge clk) !reset_n |=> !retire_valid)
        else $error("retire_valid high right after reset");

endmodule

bind cpu cpu_props props_inst (
    .clk(clk),
    .reset_n(reset_n),
    .run(run),
    .prog_ready(prog_ready),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd)
);

`default_nettype wire

/* test/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int imem_words = 256;
    localparam int dmem_words = 256;
    localparam int iaddr_w    = $clog2(imem_words);

    logic               clk;
    logic               reset_n;
    logic               run;
    logic               prog_valid;
    logic [iaddr_w-1:0] prog_addr;
    word_t              prog_data;
    logic               prog_ready;
    logic               retire_valid;
    reg_id_t            retire_rd;
    word_t              retire_data;

    word_t   prog [$];
    reg_id_t exp_rd [$];
    word_t   exp_data [$];
    int      budget = 0;

    cpu #(
        .imem_words(imem_words),
        .dmem_words(dmem_words)
    ) cpu_inst (
        .clk(clk),
        .reset_n(reset_n),
        .run(run),
        .prog_valid(prog_valid),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .prog_ready(prog_ready),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            fail_stop("retired data mismatch");
        end
    endtask

    task automatic check_reg(input string name, input reg_id_t expected, input reg_id_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected x%0d, actual x%0d", name, expected, actual);
            fail_stop("retired register mismatch");
        end
    endtask

    // rv32i encoders
    // rr kind 0..5 selects add, sub, and, or, xor or slt
    function automatic word_t rr(input int kind, input int rd, input int rs1, input int rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        case (kind)
            2:       f3 = 3'd7;
            3:       f3 = 3'd6;
            4:       f3 = 3'd4;
            5:       f3 = 3'd2;
            default: f3 = 3'd0;
        endcase
        f7 = (kind == 1) ? 7'h20 : 7'h00;
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'd0, rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'd2, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t beq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'd0, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic reset_core();
        @(negedge clk);
        run     = 1'b0;
        reset_n = 1'b0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            prog_valid = 1'b1;
            prog_addr  = iaddr_w'(i);
            prog_data  = prog[i];
            @(posedge clk);
            while (!prog_ready) @(posedge clk);
        end
        @(negedge clk);
        prog_valid = 1'b0;
    endtask

    // ISA-level model stepping one instruction at a time until the self loop
    task automatic run_model();
        word_t      regs [32];
        word_t      dmem [bit [29:0]];
        pc_t        pc;
        pc_t        next_pc;
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      val;
        word_t      addr;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        reg_id_t    rd;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       writes;
        logic       done;
        int         idx;
        int         steps;
        exp_rd.delete();
        exp_data.delete();
        foreach (regs[i]) regs[i] = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            idx     = int'(pc >> 2);
            instr   = (idx < prog.size()) ? prog[idx] : '0;
            rd      = instr[11:7];
            f3      = instr[14:12];
            f7      = instr[31:25];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            imm_i   = {{20{instr[31]}}, instr[31:20]};
            imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            next_pc = pc + 32'd4;
            writes  = 1'b0;
            val     = '0;
            case (instr[6:0])
                7'b0110011: begin
                    writes = 1'b1;
                    case (f3)
                        3'd0:    val = (f7 == 7'h20) ? a - b : a + b;
                        3'd2:    val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4:    val = a ^ b;
                        3'd6:    val = a | b;
                        3'd7:    val = a & b;
                        default: writes = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    writes = (f3 == 3'd0);
                    val    = a + imm_i;
                end
                7'b0000011: begin
                    addr   = a + imm_i;
                    writes = (f3 == 3'd2);
                    val    = dmem.exists(addr[31:2]) ? dmem[addr[31:2]] : '0;
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    if (f3 == 3'd2) begin
                        dmem[addr[31:2]] = b;
                    end
                end
                7'b1100011: begin
                    if (f3 == 3'd0 && a == b) begin
                        // branch to itself ends the program
                        if (imm_b == '0) begin
                            done = 1'b1;
                        end
                        next_pc = pc + imm_b;
                    end
                end
                default: ;
            endcase
            if (writes && rd != '0) begin
                regs[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
            end
            pc = next_pc;
            steps++;
            if (steps > 10000) begin
                fail_stop("reference model never reached the closing beq");
            end
        end
    endtask

    task automatic run_and_collect(input string name);
        int count;
        count  = 0;
        budget += 200 * exp_rd.size();
        @(negedge clk);
        run = 1'b1;
        while (count < exp_rd.size()) begin
            @(negedge clk);
            if (retire_valid) begin
                check_reg($sformatf("%s retire %0d rd", name, count), exp_rd[count], retire_rd);
                check_word($sformatf("%s retire %0d data", name, count), exp_data[count],
                           retire_data);
                count++;
            end
        end
        // the closing loop and flushed slots must stay silent
        repeat (20) begin
            @(negedge clk);
            if (retire_valid) begin
                fail_stop($sformatf("%s: retirement beyond the expected %0d", name, count));
            end
        end
        run = 1'b0;
    endtask

    task automatic run_program(input string name);
        prog.push_back(beq(0, 0, 0));
        reset_core();
        load_program();
        run_model();
        run_and_collect(name);
    endtask

    task automatic alu_ops_test();
        prog.delete();
        prog.push_back(addi(1, 0, 37));
        prog.push_back(addi(2, 0, -12));
        prog.push_back(addi(3, 0, 1000));
        prog.push_back(addi(4, 0, 1365));
        prog.push_back(rr(0, 5, 1, 2));
        prog.push_back(rr(1, 6, 1, 2));
        prog.push_back(rr(2, 7, 3, 4));
        prog.push_back(rr(3, 8, 3, 4));
        prog.push_back(rr(4, 9, 1, 4));
        prog.push_back(rr(5, 10, 2, 1));
        prog.push_back(rr(5, 11, 1, 2));
        run_program("alu_ops");
    endtask

    // dependences at distance 1, 2 and 3
    task automatic forwarding_test();
        prog.delete();
        prog.push_back(addi(1, 0, 5));
        prog.push_back(rr(0, 2, 1, 1));
        prog.push_back(rr(0, 3, 2, 1));
        prog.push_back(rr(1, 4, 3, 2));
        prog.push_back(addi(5, 0, 7));
        prog.push_back(addi(7, 0, 3));
        prog.push_back(rr(3, 8, 5, 4));
        prog.push_back(rr(5, 9, 8, 7));
        prog.push_back(rr(2, 10, 9, 3));
        prog.push_back(addi(10, 10, -100));
        run_program("forwarding");
    endtask

    task automatic load_store_test();
        prog.delete();
        prog.push_back(addi(1, 0, 64));
        prog.push_back(addi(2, 0, -77));
        prog.push_back(sw(2, 1, 8));
        prog.push_back(lw(3, 1, 8));
        prog.push_back(rr(0, 4, 3, 3));
        prog.push_back(lw(5, 1, 8));
        prog.push_back(sw(5, 1, 12));
        prog.push_back(lw(6, 1, 12));
        prog.push_back(addi(7, 6, 1));
        prog.push_back(rr(1, 8, 4, 7));
        run_program("load_store");
    endtask

    task automatic branch_test();
        prog.delete();
        prog.push_back(addi(1, 0, 3));
        prog.push_back(addi(2, 0, 3));
        prog.push_back(beq(1, 2, 12));
        prog.push_back(addi(3, 0, 111));
        prog.push_back(addi(4, 0, 222));
        prog.push_back(addi(5, 0, 5));
        prog.push_back(beq(1, 5, 8));
        prog.push_back(addi(6, 0, 6));
        prog.push_back(addi(7, 0, 7));
        prog.push_back(addi(0, 0, 9));
        prog.push_back(rr(0, 8, 6, 7));
        run_program("branches");
    endtask

    task automatic random_program_test();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int off;
        prog.delete();
        // seed registers and the four data words loads may touch
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(addi(r, 0, int'($urandom % 4096) - 2048));
        end
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(sw(r, 0, (r - 1) * 4));
        end
        for (int n = 0; n < 40; n++) begin
            kind = int'($urandom % 9);
            rd   = int'($urandom % 8);
            rs1  = int'($urandom % 8);
            rs2  = int'($urandom % 8);
            off  = int'($urandom % 4) * 4;
            if (kind < 6) begin
                prog.push_back(rr(kind, rd, rs1, rs2));
            end else if (kind == 6) begin
                prog.push_back(lw(rd, 0, off));
            end else if (kind == 7) begin
                prog.push_back(sw(rs2, 0, off));
            end else begin
                prog.push_back(addi(rd, rs1, int'($urandom % 4096) - 2048));
            end
        end
        run_program("random");
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > budget + 2000) begin
                fail_stop("timeout: retirements did not arrive in time");
            end
        end
    end

    initial begin
        void'($urandom(63191));
        reset_n    = 1'b0;
        run        = 1'b0;
        prog_valid = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        alu_ops_test();
        forwarding_test();
        load_store_test();
        branch_test();
        random_program_test();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/cpu_pkg.sv
verilog/program_memory.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/hazard_unit.sv
verilog/cpu.sv
test/cpu_props.sv
test/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
